// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - files:
      - hdl/decode_pkg.sv
      - hdl/exec_credit.sv
      - hdl/inst_queue.sv
      - hdl/op_decoder.sv
      - hdl/decode_stage.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/clock_gen.sv
      - bench/decode_tb.sv

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter real PERIOD_NS    = 20.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;   // Released on a rising edge like any input
    end

endmodule

// ==== bench/decode_checks.svh ====
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

task automatic check_op(input decoded_op_t got, input decoded_op_t exp, input string what);
    if (got !== exp) begin
        check_errors++;
        $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
        check_errors++;
        $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
endtask

// Expected execute op, written class by class from the opcode table
function automatic decoded_op_t ref_decode(input inst_word_u w);
    decoded_op_t op;
    logic [3:0]  cls;
    logic [3:0]  fn;
    logic        ok;
    logic        imm_view;
    cls      = w.imm_fmt.op_class;
    fn       = w.imm_fmt.op_func;
    op       = '0;
    ok       = 1'b0;
    imm_view = 1'b0;
    if (cls >= 4'd1 && cls <= 4'd3) begin
        ok           = (fn <= 4'd1);   // Only the two source forms
        imm_view     = (fn == 4'd0);
        op.alu_op    = (cls == 4'd3) ? ALU_MOV : ALU_ADD;
        op.mem_read  = (cls == 4'd1);
        op.mem_write = (cls == 4'd2);
        op.write_rd  = (cls != 4'd2);
    end else if (cls == 4'd4 || cls == 4'd5) begin
        ok          = (fn <= 4'd6);
        imm_view    = (cls == 4'd5);
        op.write_rd = 1'b1;
        op.reverse  = (fn == 4'd2);
        case (fn)
            4'd0:       op.alu_op = ALU_ADD;
            4'd1, 4'd2: op.alu_op = ALU_SUB;
            4'd3:       op.alu_op = ALU_AND;
            4'd4:       op.alu_op = ALU_OR;
            4'd5:       op.alu_op = ALU_XOR;
            default:    op.alu_op = ALU_BIC;
        endcase
    end else if (cls == 4'd6 || cls == 4'd7) begin
        ok        = (fn == 4'd1 || fn == 4'd3);   // cmp and tst
        imm_view  = (cls == 4'd7);
        op.alu_op = (fn == 4'd3) ? ALU_AND : ALU_SUB;
    end
    if (ok) begin
        op.rd      = w.reg_fmt.rd;
        op.rm      = w.reg_fmt.rm;
        op.rn      = w.reg_fmt.rn;
        op.use_imm = imm_view;
        if (imm_view) begin
            op.imm = w.imm_fmt.imm;
        end else begin
            op.shift     = w.reg_fmt.shift;
            op.shift_dir = w.reg_fmt.shift_dir;
        end
    end else begin
        op         = '0;
        op.alu_op  = ALU_NOP;
        op.illegal = 1'b1;
    end
    return op;
endfunction

`endif

// ==== bench/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb;
    import decode_pkg::*;

    localparam int QUEUE_DEPTH  = QUEUE_DEPTH_DEF;
    localparam int EXEC_CREDITS = EXEC_CREDITS_DEF;
    localparam int WAIT_LIMIT   = 200;   // Cycles per wait

    logic        clk;
    logic        reset;
    logic        fetch_valid;
    inst_word_u  fetch_inst;
    logic        fetch_credit;
    logic        exec_valid;
    decoded_op_t exec_op;
    logic        exec_credit_return = 1'b0;

    int          check_errors;
    int          timeout_errors;
    int          fetch_credits;   // Fetch side credit model
    int          credit_pulses;
    int          returns_owed;    // Execute slots still to hand back
    bit          auto_return;
    int          neg_cycle;
    logic [15:0] lfsr_state;
    decoded_op_t exp_ops[$];
    decoded_op_t got_ops[$];
    int          sent_cycle[$];
    int          got_cycle[$];

    clock_gen #(.PERIOD_NS(20.0), .RESET_CYCLES(4)) u_clock (.clk(clk), .reset(reset));

    decode_stage #(
        .QUEUE_DEPTH        (QUEUE_DEPTH),
        .EXEC_CREDITS       (EXEC_CREDITS)
    ) dut (
        .clk                (clk),
        .reset              (reset),
        .fetch_valid        (fetch_valid),
        .fetch_inst         (fetch_inst),
        .fetch_credit       (fetch_credit),
        .exec_valid         (exec_valid),
        .exec_op            (exec_op),
        .exec_credit_return (exec_credit_return)
    );

    `include "decode_checks.svh"

    // DUT outputs are sampled on the falling edge
    always @(negedge clk) begin
        neg_cycle = neg_cycle + 1;
        if (!reset && exec_valid) begin
            got_ops.push_back(exec_op);
            got_cycle.push_back(neg_cycle);
            if (auto_return) returns_owed = returns_owed + 1;   // Execute frees the slot
        end
        if (!reset && fetch_credit) begin
            fetch_credits = fetch_credits + 1;
            credit_pulses = credit_pulses + 1;
        end
    end

    always @(posedge clk) begin
        if (!reset && returns_owed > 0) begin
            exec_credit_return <= 1'b1;
            returns_owed = returns_owed - 1;
        end else begin
            exec_credit_return <= 1'b0;
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic lfsr_step();
        logic fb;
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    task automatic send_word(input inst_word_u w, input decoded_op_t expected);
        int waited;
        waited = 0;
        @(posedge clk);
        while (fetch_credits == 0 && waited < WAIT_LIMIT) begin
            fetch_valid <= 1'b0;
            waited++;
            @(posedge clk);
        end
        if (fetch_credits == 0) begin
            timeout_errors++;
            $display("TIMEOUT at %0t: fetch never got a queue credit back", $time);
        end else begin
            fetch_valid   <= 1'b1;
            fetch_inst    <= w;
            fetch_credits = fetch_credits - 1;
            exp_ops.push_back(expected);
            sent_cycle.push_back(neg_cycle);
        end
    endtask

    task automatic stop_fetch();
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    task automatic wait_ops(input int n);
        int waited;
        waited = 0;
        while (got_ops.size() < n && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (got_ops.size() < n) begin
            timeout_errors++;
            $display("TIMEOUT at %0t: only %0d of %0d operations issued", $time,
                     got_ops.size(), n);
        end
    endtask

    task automatic compare_received(input bit check_latency);
        decoded_op_t got;
        decoded_op_t exp;
        int          latency;
        check_count(got_ops.size(), exp_ops.size(), "operations issued");
        while (got_ops.size() > 0 && exp_ops.size() > 0) begin
            got     = got_ops.pop_front();
            exp     = exp_ops.pop_front();
            latency = got_cycle.pop_front() - sent_cycle.pop_front() - 1;
            check_op(got, exp, "issued operation");
            if (check_latency) check_count(latency, 2, "cycles from fetch to issue");
        end
        got_ops.delete();
        exp_ops.delete();
        got_cycle.delete();
        sent_cycle.delete();
    endtask

    task automatic idle_after_reset();
        int i;
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            check_count(exec_valid === 1'b0 ? 0 : 1, 0, "exec_valid after reset");
            check_count(fetch_credit === 1'b0 ? 0 : 1, 0, "fetch_credit after reset");
        end
    endtask

    task automatic legal_pairs();
        inst_word_u  w;
        decoded_op_t exp;
        int          cls;
        int          fn;
        for (cls = 1; cls <= 7 && timeout_errors == 0; cls++) begin
            for (fn = 0; fn < 16 && timeout_errors == 0; fn++) begin
                w                  = rand_bits(32);
                w.reg_fmt.op_class = op_class_t'(cls);
                w.reg_fmt.op_func  = op_func_t'(fn);
                exp                = ref_decode(w);
                if (!exp.illegal) begin
                    send_word(w, exp);
                    stop_fetch();
                    wait_ops(1);
                    compare_received(1'b1);
                end
            end
        end
    endtask

    task automatic illegal_words();
        inst_word_u  w;
        decoded_op_t bad;
        logic [7:0]  codes [16];
        int          i;
        codes = '{8'h03, 8'h80, 8'h91, 8'hA2, 8'hB3, 8'hC4, 8'hD5, 8'hE6, 8'hFF,
                  8'h12, 8'h2F, 8'h34, 8'h47, 8'h5C, 8'h65, 8'h70};
        bad         = '0;
        bad.alu_op  = ALU_NOP;   // Nothing executes, nothing is written
        bad.illegal = 1'b1;
        for (i = 0; i < 16 && timeout_errors == 0; i++) begin
            w = rand_bits(32);
            w[31:24] = codes[i];
            send_word(w, bad);
        end
        stop_fetch();
        wait_ops(16);
        compare_received(1'b0);
    endtask

    task automatic exec_backpressure();
        inst_word_u w;
        int         i;
        int         waited;
        waited = 0;
        while (returns_owed != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (returns_owed != 0) begin
            timeout_errors++;
            $display("TIMEOUT at %0t: execute credits from earlier ops never returned", $time);
        end
        repeat (2) @(posedge clk);   // Last return reaches the counter
        auto_return = 1'b0;
        for (i = 0; i < 8 && timeout_errors == 0; i++) begin
            w     = rand_bits(32);
            w[31] = 1'b0;
            send_word(w, ref_decode(w));
        end
        stop_fetch();
        repeat (10) @(negedge clk);
        check_count(got_ops.size(), EXEC_CREDITS, "issues with no credit returned");
        auto_return = 1'b1;
        @(negedge clk);
        returns_owed = returns_owed + EXEC_CREDITS;
        wait_ops(8);
        compare_received(1'b0);
    endtask

    task automatic random_stream();
        inst_word_u w;
        int         pulses_before;
        int         consumed;
        int         i;
        pulses_before = credit_pulses;
        for (i = 0; i < 40 && timeout_errors == 0; i++) begin
            w     = rand_bits(32);
            w[31] = 1'b0;   // Mostly legal classes
            send_word(w, ref_decode(w));
        end
        stop_fetch();
        wait_ops(40);
        consumed = got_ops.size();
        check_count(credit_pulses - pulses_before, consumed, "fetch credits per word consumed");
        check_count(fetch_credits, QUEUE_DEPTH, "fetch credits once drained");
        compare_received(1'b0);
    endtask

    initial begin
        int waited;
        fetch_valid    = 1'b0;
        fetch_inst     = '0;
        check_errors   = 0;
        timeout_errors = 0;
        fetch_credits  = QUEUE_DEPTH;
        credit_pulses  = 0;
        returns_owed   = 0;
        auto_return    = 1'b1;
        neg_cycle      = 0;
        lfsr_state     = 16'd52256;
        waited         = 0;
        @(negedge clk);
        while (reset !== 1'b0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (reset !== 1'b0) begin
            timeout_errors++;
            $display("TIMEOUT at %0t: reset was never released", $time);
        end
        if (timeout_errors == 0) idle_after_reset();
        if (timeout_errors == 0) legal_pairs();
        if (timeout_errors == 0) illegal_words();
        if (timeout_errors == 0) exec_backpressure();
        if (timeout_errors == 0) random_stream();
        $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== hdl/decode_pkg.sv ====
package decode_pkg;

    // Default sizing, overridden from the top level
    localparam int QUEUE_DEPTH_DEF  = 4;    // Also fetch credits after reset
    localparam int EXEC_CREDITS_DEF = 4;    // Slots in the execute input buffer

    typedef logic [3:0]  reg_idx_t;         // 16 registers
    typedef logic [4:0]  shift_amt_t;
    typedef logic [15:0] imm_t;

    typedef enum logic [1:0] {
        SHIFT_LSL = 2'd0,
        SHIFT_LSR = 2'd1,
        SHIFT_ASR = 2'd2,
        SHIFT_ROR = 2'd3
    } shift_dir_t;

    // Upper opcode nibble; unlisted values decode as illegal
    typedef enum logic [3:0] {
        CLS_LOAD    = 4'd1,
        CLS_STORE   = 4'd2,
        CLS_MOVE    = 4'd3,
        CLS_ALU_REG = 4'd4,
        CLS_ALU_IMM = 4'd5,
        CLS_CMP_REG = 4'd6,
        CLS_CMP_IMM = 4'd7
    } op_class_t;

    // Lower opcode nibble, meaning depends on the class
    typedef enum logic [3:0] {
        FN_ADD  = 4'd0,
        FN_SUB  = 4'd1,
        FN_RSUB = 4'd2,
        FN_AND  = 4'd3,
        FN_OR   = 4'd4,
        FN_XOR  = 4'd5,
        FN_BIC  = 4'd6
    } op_func_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_BIC = 3'd5,
        ALU_MOV = 3'd6,
        ALU_NOP = 3'd7
    } alu_op_t;

    // Register form, second operand is a shifted rn
    typedef struct packed {
        op_class_t  op_class;   // 31..28
        op_func_t   op_func;    // 27..24
        reg_idx_t   rd;         // 23..20
        reg_idx_t   rm;         // 19..16
        reg_idx_t   rn;         // 15..12
        shift_amt_t shift;      // 11..7
        shift_dir_t shift_dir;  // 6..5
        logic [4:0] reserved;
    } inst_reg_t;

    // Immediate form, low half is the literal
    typedef struct packed {
        op_class_t  op_class;
        op_func_t   op_func;
        reg_idx_t   rd;
        reg_idx_t   rm;
        imm_t       imm;        // 15..0
    } inst_imm_t;

    // Same 32-bit word, view picked by the class
    typedef union packed {
        inst_reg_t reg_fmt;
        inst_imm_t imm_fmt;
    } inst_word_u;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       reverse;    // Operand order swapped, rsub
        logic       use_imm;    // Second operand is imm
        logic       mem_read;
        logic       mem_write;
        logic       write_rd;
        logic       illegal;
        reg_idx_t   rd;
        reg_idx_t   rm;
        reg_idx_t   rn;
        shift_amt_t shift;      // Zero in immediate forms
        shift_dir_t shift_dir;
        imm_t       imm;        // Zero in register forms
    } decoded_op_t;

endpackage

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage #(
    parameter int QUEUE_DEPTH  = decode_pkg::QUEUE_DEPTH_DEF,
    parameter int EXEC_CREDITS = decode_pkg::EXEC_CREDITS_DEF
) (
    input  logic                    clk,
    input  logic                    reset,

    // Fetch side, credit per queue slot
    input  logic                    fetch_valid,
    input  decode_pkg::inst_word_u  fetch_inst,
    output logic                    fetch_credit,

    // Execute side, credit per buffer slot
    output logic                    exec_valid,
    output decode_pkg::decoded_op_t exec_op,
    input  logic                    exec_credit_return
);
    import decode_pkg::*;

    logic       head_valid;
    inst_word_u head_word;
    logic       pop;          // Also the issue strobe
    logic       may_issue;

    inst_queue #(
        .DEPTH      (QUEUE_DEPTH)
    ) u_queue (
        .clk        (clk),
        .reset      (reset),
        .push       (fetch_valid),
        .push_word  (fetch_inst),
        .pop        (pop),
        .head_valid (head_valid),
        .head_word  (head_word),
        .pop_credit (fetch_credit)
    );

    op_decoder u_decoder (
        .clk        (clk),
        .reset      (reset),
        .head_valid (head_valid),
        .head_word  (head_word),
        .may_issue  (may_issue),
        .pop        (pop),
        .exec_valid (exec_valid),
        .exec_op    (exec_op)
    );

    exec_credit #(
        .CREDITS       (EXEC_CREDITS)
    ) u_credit (
        .clk           (clk),
        .reset         (reset),
        .spend         (pop),
        .credit_return (exec_credit_return),
        .may_issue     (may_issue)
    );

endmodule

// ==== hdl/exec_credit.sv ====
`timescale 1ns/1ps

module exec_credit #(
    parameter int CREDITS = decode_pkg::EXEC_CREDITS_DEF
) (
    input  logic clk,
    input  logic reset,
    input  logic spend,
    input  logic credit_return,
    output logic may_issue
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] count;

    assign may_issue = (count != '0);

    // Spend and return in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= CNT_W'(CREDITS);   // Execute buffer starts empty
        end else begin
            case ({spend, credit_return})
                2'b10: begin
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end
                end
                2'b01: begin
                    if (count != CNT_W'(CREDITS)) begin
                        count <= count + 1'b1;   // Saturate at full
                    end
                end
                default: count <= count;
            endcase
        end
    end

    // A return on a full counter means execute freed a slot never spent
    no_credit_overflow: assert property (
        @(posedge clk) disable iff (reset)
        (credit_return && !spend) |-> (count < CNT_W'(CREDITS))
    ) else $error("exec_credit: credit returned beyond CREDITS");

endmodule

// ==== hdl/inst_queue.sv ====
`timescale 1ns/1ps

module inst_queue #(
    parameter int DEPTH = decode_pkg::QUEUE_DEPTH_DEF
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  decode_pkg::inst_word_u push_word,
    input  logic                   pop,
    output logic                   head_valid,
    output decode_pkg::inst_word_u head_word,
    output logic                   pop_credit
);
    import decode_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    inst_word_u       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head_valid = (count != '0);
    assign head_word  = mem[rd_ptr];   // Visible the cycle after the push

    // Storage holds payload only
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            pop_credit <= 1'b0;
        end else begin
            pop_credit <= pop;   // One fetch credit back per entry popped
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // Fetch pushed without holding a credit
    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset)
        push |-> (count != CNT_W'(DEPTH))
    ) else $error("inst_queue: push while full, fetch credit violated");

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset)
        pop |-> head_valid
    ) else $error("inst_queue: pop while empty");

endmodule

// ==== hdl/op_decoder.sv ====
`timescale 1ns/1ps

module op_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    head_valid,
    input  decode_pkg::inst_word_u  head_word,
    input  logic                    may_issue,
    output logic                    pop,
    output logic                    exec_valid,
    output decode_pkg::decoded_op_t exec_op
);
    import decode_pkg::*;

    decoded_op_t dec;
    logic        legal;
    logic        imm_form;

    assign pop = head_valid && may_issue;   // Pop and issue are the same event

    always_comb begin
        dec      = '0;
        dec.alu_op = ALU_NOP;
        legal    = 1'b1;
        imm_form = 1'b0;

        case (head_word.reg_fmt.op_class)
            CLS_LOAD, CLS_STORE: begin
                dec.alu_op    = ALU_ADD;   // Address is rm plus offset
                dec.mem_read  = (head_word.reg_fmt.op_class == CLS_LOAD);
                dec.mem_write = (head_word.reg_fmt.op_class == CLS_STORE);
                dec.write_rd  = (head_word.reg_fmt.op_class == CLS_LOAD);
                case (head_word.reg_fmt.op_func)
                    FN_ADD:  imm_form = 1'b1;   // [rm + imm]
                    FN_SUB:  imm_form = 1'b0;   // [rm + sh(rn)]
                    default: legal    = 1'b0;
                endcase
            end

            CLS_MOVE: begin
                dec.alu_op   = ALU_MOV;
                dec.write_rd = 1'b1;
                case (head_word.reg_fmt.op_func)
                    FN_ADD:  imm_form = 1'b1;   // rd <- imm
                    FN_SUB:  imm_form = 1'b0;   // rd <- sh(rn)
                    default: legal    = 1'b0;
                endcase
            end

            CLS_ALU_REG, CLS_ALU_IMM: begin
                imm_form     = (head_word.reg_fmt.op_class == CLS_ALU_IMM);
                dec.write_rd = 1'b1;
                case (head_word.reg_fmt.op_func)
                    FN_ADD:  dec.alu_op = ALU_ADD;
                    FN_SUB:  dec.alu_op = ALU_SUB;
                    FN_RSUB: begin
                        dec.alu_op  = ALU_SUB;
                        dec.reverse = 1'b1;   // Second operand minus rm
                    end
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_BIC:  dec.alu_op = ALU_BIC;
                    default: legal = 1'b0;
                endcase
            end

            // Flags only, so no register write
            CLS_CMP_REG, CLS_CMP_IMM: begin
                imm_form = (head_word.reg_fmt.op_class == CLS_CMP_IMM);
                case (head_word.reg_fmt.op_func)
                    FN_SUB:  dec.alu_op = ALU_SUB;   // cmp
                    FN_AND:  dec.alu_op = ALU_AND;   // tst
                    default: legal = 1'b0;
                endcase
            end

            default: legal = 1'b0;
        endcase

        if (legal) begin
            dec.rd      = head_word.reg_fmt.rd;
            dec.rm      = head_word.reg_fmt.rm;
            dec.rn      = head_word.reg_fmt.rn;
            dec.use_imm = imm_form;
            if (imm_form) begin
                dec.imm = head_word.imm_fmt.imm;
            end else begin
                dec.shift     = head_word.reg_fmt.shift;
                dec.shift_dir = head_word.reg_fmt.shift_dir;
            end
        end else begin
            dec         = '0;
            dec.alu_op  = ALU_NOP;
            dec.illegal = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= pop;   // One cycle per issued op
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            exec_op <= dec;
        end
    end

endmodule

// ==== src.f ====
+incdir+bench
hdl/decode_pkg.sv
hdl/exec_credit.sv
hdl/inst_queue.sv
hdl/op_decoder.sv
hdl/decode_stage.sv
bench/clock_gen.sv
bench/decode_tb.sv
